// ==== vlog.f ====
+incdir+tests
source/matrix_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/matrix_loader.sv
source/matrix_store.sv
source/matrix_alu.sv
source/result_sender.sv
source/matrix_calc_top.sv
tests/matrix_calc_sva.sv
tests/tb_matrix_calc.sv

// ==== Makefile ====
# Verilator build and run of the matrix calculator testbench
VERILATOR ?= verilator
TOP       ?= tb_matrix_calc
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_matrix_calc_tasks.svh ====
//==========================================================================
// Testbench tasks: UART frame driver, operand loading, op start,
// result collection and idle line checks
//==========================================================================
`ifndef TB_MATRIX_CALC_TASKS_SVH
`define TB_MATRIX_CALC_TASKS_SVH

  // One frame on uart_rx, start bit, data LSB first, stop bit
  task automatic send_frame(input elem_t data);
    logic [9:0] bits;
    int i;
    bits = {1'b1, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= bits[0];
      bits = {1'b1, bits[9:1]};
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // Header then random elements, the model keeps its own copy
  task automatic load_matrix(input logic to_b, input int rows, input int cols);
    elem_t vals[$];
    int i;
    for (i = 0; i < rows * cols; i++) begin
      vals.push_back(next_rand());
    end
    if (to_b) begin
      mat_b = vals;
      b_cols = cols;
    end else begin
      mat_a = vals;
      a_rows = rows;
      a_cols = cols;
    end
    send_frame({3'b000, to_b, 2'(rows - 1), 2'(cols - 1)});
    for (i = 0; i < rows * cols; i++) begin
      send_frame(vals[i]);
    end
    // Last write lands one cycle after rx_valid, flag one more
    repeat (4) @(posedge clk);
  endtask

  // Switches and a one-cycle button pulse
  task automatic press_confirm(input op_t op, input elem_t scalar);
    @(posedge clk);
    sw_mode_sel   <= op;
    sw_scalar_val <= scalar;
    btn_confirm   <= 1'b1;
    @(posedge clk);
    btn_confirm   <= 1'b0;
  endtask

  task automatic run_op(input op_t op, input elem_t scalar);
    build_expected(op, scalar);
    press_confirm(op, scalar);
    // Busy LED lights in the first cycle of the calculation
    @(negedge clk);
    check_value({7'h0, led_status[3]}, 8'h01, "busy LED after start");
  endtask

  // Poll until the monitor has decoded n bytes
  task automatic wait_bytes(input int n);
    while (rx_q.size() < n) @(posedge clk);
  endtask

  // Whole stream against the model, header first
  task automatic check_result(input string what);
    elem_t got;
    int i;
    wait_bytes(exp_q.size());
    for (i = 0; i < exp_q.size(); i++) begin
      got = rx_q.pop_front();
      check_value(got, exp_q[i], $sformatf("%s byte %0d", what, i));
    end
  endtask

  // Line stays high and no byte arrives
  task automatic check_idle(input int cycles, input string what);
    int i;
    for (i = 0; i < cycles; i++) begin
      @(negedge clk);
      check_value({7'h0, uart_tx}, 8'h01, what);
    end
    check_value(8'(rx_q.size()), 8'h00, {what, ", bytes received"});
  endtask

`endif

// ==== tests/tb_matrix_calc.sv ====
//==========================================================================
// Matrix calculator testbench: clock, reset, UART monitor, LFSR
// stimulus, reference model, result checks and run timeout
//==========================================================================
`timescale 1ns/1ns

module tb_matrix_calc;
  import matrix_pkg::*;

  localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
  // 38 frames in, 40 out, about four frames of idle checks
  localparam int RX_FRAMES = 38;
  localparam int TX_FRAMES = 40;
  localparam int IDLE_FRAMES = 4;
  localparam int TIMEOUT_CYCLES = (RX_FRAMES + TX_FRAMES + IDLE_FRAMES) * FRAME_CYCLES + 500;

  logic             clk;
  logic             rst_n;
  logic             uart_rx;
  op_t              sw_mode_sel;
  elem_t            sw_scalar_val;
  logic             btn_confirm;
  logic             uart_tx;
  logic [LED_W-1:0] led_status;

  // Loaded operands, row-major, with their sizes
  elem_t mat_a[$];
  elem_t mat_b[$];
  int    a_rows, a_cols, b_cols;
  // Expected and decoded result streams
  elem_t exp_q[$];
  elem_t rx_q[$];
  elem_t lfsr_q;
  int    cycle_cnt;

  matrix_calc_top i_dut (.*);

  always #4 clk = ~clk;

  //==========================================================================
  // Failure reporting and checks
  //==========================================================================
  task automatic fail_stop(input string why);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input elem_t got, input elem_t exp, input string what);
    assert (got == exp) else begin
      $display("mismatch at %0t ns: %s, got 8'h%02h, expected 8'h%02h", $time, what, got, exp);
      fail_stop("value check failed");
    end
  endtask

  // Fibonacci LFSR x^8+x^6+x^5+x^4+1, one step per bit taken
  function automatic elem_t next_rand();
    elem_t val;
    int k;
    val = '0;
    for (k = 0; k < 8; k++) begin
      lfsr_q = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      val = {val[6:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // Reference stream: header, then result elements row-major
  task automatic build_expected(input op_t op, input elem_t scalar);
    int rows;
    int cols;
    int r;
    int c;
    elem_t a;
    elem_t b;
    elem_t res;
    rows = (op == OP_TRANSPOSE) ? a_cols : a_rows;
    cols = (op == OP_TRANSPOSE) ? a_rows : a_cols;
    exp_q.delete();
    exp_q.push_back({4'h0, 2'(rows - 1), 2'(cols - 1)});
    for (r = 0; r < rows; r++) begin
      for (c = 0; c < cols; c++) begin
        a = (op == OP_TRANSPOSE) ? mat_a[c * a_cols + r] : mat_a[r * a_cols + c];
        b = (op == OP_ADD || op == OP_SUB) ? mat_b[r * b_cols + c] : 8'h00;
        case (op)
          OP_ADD:   res = a + b;
          OP_SUB:   res = a - b;
          OP_SCALE: res = a * scalar;
          default:  res = a;
        endcase
        exp_q.push_back(res);
      end
    end
  endtask

  `include "tb_matrix_calc_tasks.svh"

  // Run limit from the frame count
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      fail_stop($sformatf("run timed out after %0d cycles", cycle_cnt));
    end
  end

  // Decode uart_tx, sampled mid-bit on the falling clock edge
  initial begin : tx_monitor
    elem_t data;
    int i;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && uart_tx === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        for (i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          data = {uart_tx, data[7:1]};
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (uart_tx === 1'b1) else begin
          fail_stop($sformatf("framing error, stop bit low on uart_tx at %0t ns", $time));
        end
        rx_q.push_back(data);
      end
    end
  end

  //==========================================================================
  // Test sequence
  //==========================================================================
  initial begin : run_tests
    elem_t scalar;
    int i;
    clk = 1'b0;
    rst_n = 1'b0;
    uart_rx = 1'b1;
    sw_mode_sel = OP_ADD;
    sw_scalar_val = 8'h00;
    btn_confirm = 1'b0;
    lfsr_q = 8'd37;
    cycle_cnt = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Idle line and dark LEDs before any load
    for (i = 0; i < 8; i++) begin
      @(negedge clk);
      check_value({7'h0, uart_tx}, 8'h01, "uart_tx after reset");
      check_value({4'h0, led_status}, 8'h00, "led_status after reset");
    end

    // 3x2 operands, add
    load_matrix(1'b0, 3, 2);
    load_matrix(1'b1, 3, 2);
    check_value({6'h0, led_status[1:0]}, 8'h03, "slot valid LEDs after load");
    run_op(OP_ADD, 8'h00);
    check_result("add");

    // Subtract wraps, then scale by a random value
    run_op(OP_SUB, 8'h00);
    check_result("subtract");
    scalar = next_rand();
    run_op(OP_SCALE, scalar);
    check_result("scale");

    // 2x4 comes back as 4x2
    load_matrix(1'b0, 2, 4);
    run_op(OP_TRANSPOSE, 8'h00);
    check_result("transpose");

    // Size mismatch, error LED and a silent line
    load_matrix(1'b0, 2, 2);
    load_matrix(1'b1, 3, 3);
    press_confirm(OP_ADD, 8'h00);
    @(negedge clk);
    check_value({7'h0, led_status[2]}, 8'h01, "error LED after size mismatch");
    check_idle(MAX_DIM * MAX_DIM + 4, "uart_tx after size error");
    scalar = next_rand();
    run_op(OP_SCALE, scalar);
    @(negedge clk);
    check_value({7'h0, led_status[2]}, 8'h00, "error LED after valid op");
    check_result("scale after error");

    // Extra press during the stream is ignored
    run_op(OP_TRANSPOSE, 8'h00);
    wait_bytes(1);
    press_confirm(OP_SCALE, 8'h03);
    check_result("transpose with extra press");
    check_idle(3 * FRAME_CYCLES, "line after single result");

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== tests/matrix_calc_sva.sv ====
//==========================================================================
// Protocol assertions for the matrix calculator top: transmitter start
// rules, idle line level and result slot write window
//==========================================================================
`timescale 1ns/1ns

module matrix_calc_sva (
  input logic clk,
  input logic rst_n,
  input logic tx_start,
  input logic tx_busy,
  input logic uart_tx,
  input logic alu_wr_new,
  input logic alu_wr_en,
  input logic alu_busy
);

  // Transmitter takes a byte only when idle
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else $error("tx_start raised while the transmitter was busy");

  // ALU writes to the result slot only while busy
  a_res_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_wr_new || alu_wr_en) |-> alu_busy)
    else $error("result slot written outside the ALU busy time");

  // Idle line is high
  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> uart_tx)
    else $error("uart_tx low while the transmitter was idle");

endmodule

bind matrix_calc_top matrix_calc_sva i_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .tx_start   (tx_start),
  .tx_busy    (tx_busy),
  .uart_tx    (uart_tx),
  .alu_wr_new (alu_wr_new),
  .alu_wr_en  (alu_wr_en),
  .alu_busy   (alu_busy)
);

// ==== source/matrix_calc_top.sv ====
//==========================================================================
// Matrix calculator top: UART receive and load, store, ALU,
// result sender and UART transmit, plus status LEDs
//==========================================================================
`timescale 1ns/1ns

module matrix_calc_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         uart_rx,
  input  matrix_pkg::op_t              sw_mode_sel,
  input  matrix_pkg::elem_t            sw_scalar_val,
  input  logic                         btn_confirm,
  output logic                         uart_tx,
  output logic [matrix_pkg::LED_W-1:0] led_status
);
  import matrix_pkg::*;

  //==========================================================================
  // Interconnect, named after the ports they join
  //==========================================================================
  // Receive side
  elem_t             rx_byte;
  logic              rx_valid;
  logic              load_wr_new, load_wr_en, load_last;
  logic [SLOT_W-1:0] load_slot;
  logic [DIM_W-1:0]  load_rows, load_cols, load_row, load_col;
  elem_t             load_data;

  // ALU result writes
  logic              alu_wr_new, alu_wr_en, alu_last;
  logic [DIM_W-1:0]  alu_rows, alu_cols, alu_row, alu_col;
  elem_t             alu_data;
  logic              alu_done, alu_busy, alu_err;

  // Store reads
  logic [DIM_W-1:0]  a_row, a_col, b_row, b_col, r_row, r_col;
  logic [DIM_W-1:0]  a_rows, a_cols, b_rows, b_cols, r_rows, r_cols;
  elem_t             a_data, b_data, r_data;
  logic [2:0]        slot_valid;

  // Transmit side
  logic              sender_busy;
  logic              tx_start, tx_busy;
  elem_t             tx_byte;

  uart_rx u_uart_rx (.*);

  matrix_loader u_loader (.*);

  matrix_store u_store (.*);

  // Switches and slot flags go by other names here
  matrix_alu u_alu (
    .op_sel  (sw_mode_sel),
    .scalar  (sw_scalar_val),
    .a_valid (slot_valid[SLOT_A]),
    .b_valid (slot_valid[SLOT_B]),
    .*
  );

  result_sender u_sender (.*);

  uart_tx u_uart_tx (.*);

  // LED 0 A valid, 1 B valid, 2 error, 3 busy
  assign led_status = {alu_busy, alu_err, slot_valid[SLOT_B], slot_valid[SLOT_A]};

endmodule

// ==== source/result_sender.sv ====
//==========================================================================
// Result streamer: header byte, then result elements in row-major
// order, each handed to the UART transmitter once it is idle
//==========================================================================
`timescale 1ns/1ns

module result_sender (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         alu_done,
  input  logic [matrix_pkg::DIM_W-1:0] r_rows,
  input  logic [matrix_pkg::DIM_W-1:0] r_cols,
  input  matrix_pkg::elem_t            r_data,
  output logic [matrix_pkg::DIM_W-1:0] r_row,
  output logic [matrix_pkg::DIM_W-1:0] r_col,
  input  logic                         tx_busy,
  output logic                         tx_start,
  output matrix_pkg::elem_t            tx_byte,
  output logic                         sender_busy
);
  import matrix_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEND,
    S_GAP
  } snd_state_t;

  snd_state_t state;
  logic       hdr_q;
  logic       send_now;
  logic       at_last;

  assign send_now    = (state == S_SEND) && !tx_busy;
  assign at_last     = (r_row == r_rows) && (r_col == r_cols);
  assign sender_busy = (state != S_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      hdr_q    <= 1'b0;
      r_row    <= '0;
      r_col    <= '0;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (alu_done) begin
            hdr_q <= 1'b1;
            r_row <= '0;
            r_col <= '0;
            state <= S_SEND;
          end
        end
        S_SEND: begin
          if (send_now) begin
            tx_start <= 1'b1;
            state    <= S_GAP;
          end
        end
        default: begin
          // tx_busy rises only after this cycle
          if (hdr_q) begin
            hdr_q <= 1'b0;
            state <= S_SEND;
          end else if (at_last) begin
            state <= S_IDLE;
          end else begin
            state <= S_SEND;
            r_col <= (r_col == r_cols) ? '0 : r_col + 1'b1;
            if (r_col == r_cols) r_row <= r_row + 1'b1;
          end
        end
      endcase
    end
  end

  // Header carries dimensions, slot bit clear
  always_ff @(posedge clk) begin
    if (send_now) tx_byte <= hdr_q ? {4'h0, r_rows, r_cols} : r_data;
  end

endmodule

// ==== source/matrix_alu.sv ====
//==========================================================================
// Element-serial ALU: operand check at start, then one result element
// per cycle into the result slot for add, subtract, scale, transpose
//==========================================================================
`timescale 1ns/1ns

module matrix_alu (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         btn_confirm,
  input  matrix_pkg::op_t              op_sel,
  input  matrix_pkg::elem_t            scalar,
  // Operand A read port
  output logic [matrix_pkg::DIM_W-1:0] a_row,
  output logic [matrix_pkg::DIM_W-1:0] a_col,
  input  matrix_pkg::elem_t            a_data,
  input  logic [matrix_pkg::DIM_W-1:0] a_rows,
  input  logic [matrix_pkg::DIM_W-1:0] a_cols,
  input  logic                         a_valid,
  // Operand B read port
  output logic [matrix_pkg::DIM_W-1:0] b_row,
  output logic [matrix_pkg::DIM_W-1:0] b_col,
  input  matrix_pkg::elem_t            b_data,
  input  logic [matrix_pkg::DIM_W-1:0] b_rows,
  input  logic [matrix_pkg::DIM_W-1:0] b_cols,
  input  logic                         b_valid,
  input  logic                         sender_busy,
  // Result write port
  output logic                         alu_wr_new,
  output logic                         alu_wr_en,
  output logic [matrix_pkg::DIM_W-1:0] alu_rows,
  output logic [matrix_pkg::DIM_W-1:0] alu_cols,
  output logic [matrix_pkg::DIM_W-1:0] alu_row,
  output logic [matrix_pkg::DIM_W-1:0] alu_col,
  output matrix_pkg::elem_t            alu_data,
  output logic                         alu_last,
  output logic                         alu_done,
  output logic                         alu_busy,
  output logic                         alu_err
);
  import matrix_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_FINISH
  } alu_state_t;

  alu_state_t       state;
  op_t              op_q;
  elem_t            scalar_q;
  elem_t            result;
  logic [DIM_W-1:0] row_q;
  logic [DIM_W-1:0] col_q;
  logic             start;
  logic             operands_ok;
  logic             at_last;

  // Busy covers the done cycle so a button there is not taken
  assign alu_busy = (state != S_IDLE) || alu_done;
  assign start    = btn_confirm && !alu_busy && !sender_busy;
  assign at_last  = (row_q == alu_rows) && (col_q == alu_cols);

  // Transpose reads A at (col, row)
  assign a_row = (op_q == OP_TRANSPOSE) ? col_q : row_q;
  assign a_col = (op_q == OP_TRANSPOSE) ? row_q : col_q;
  assign b_row = row_q;
  assign b_col = col_q;

  // Two-operand ops need both slots with equal sizes
  always_comb begin
    if (op_sel == OP_ADD || op_sel == OP_SUB) begin
      operands_ok = a_valid && b_valid && (a_rows == b_rows) && (a_cols == b_cols);
    end else begin
      operands_ok = a_valid;
    end
  end

  // Wrapping element ops, scale keeps the low product byte
  always_comb begin
    unique case (op_q)
      OP_ADD:   result = a_data + b_data;
      OP_SUB:   result = a_data - b_data;
      OP_SCALE: result = a_data * scalar_q;
      default:  result = a_data;
    endcase
  end

  //==========================================================================
  // Control
  //==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      op_q       <= OP_ADD;
      row_q      <= '0;
      col_q      <= '0;
      alu_rows   <= '0;
      alu_cols   <= '0;
      alu_row    <= '0;
      alu_col    <= '0;
      alu_wr_new <= 1'b0;
      alu_wr_en  <= 1'b0;
      alu_last   <= 1'b0;
      alu_done   <= 1'b0;
      alu_err    <= 1'b0;
    end else begin
      alu_wr_new <= 1'b0;
      alu_wr_en  <= 1'b0;
      alu_done   <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            op_q     <= op_sel;
            alu_err  <= !operands_ok;
            row_q    <= '0;
            col_q    <= '0;
            // Result shape, swapped for transpose
            alu_rows <= (op_sel == OP_TRANSPOSE) ? a_cols : a_rows;
            alu_cols <= (op_sel == OP_TRANSPOSE) ? a_rows : a_cols;
            if (operands_ok) begin
              alu_wr_new <= 1'b1;
              state      <= S_RUN;
            end
          end
        end
        S_RUN: begin
          alu_wr_en <= 1'b1;
          alu_row   <= row_q;
          alu_col   <= col_q;
          alu_last  <= at_last;
          // Row-major walk of the result
          if (at_last) begin
            state <= S_FINISH;
          end else if (col_q == alu_cols) begin
            col_q <= '0;
            row_q <= row_q + 1'b1;
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        S_FINISH: begin
          alu_done <= 1'b1;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) scalar_q <= scalar;
    if (state == S_RUN) alu_data <= result;
  end

endmodule

// ==== source/matrix_store.sv ====
//==========================================================================
// Matrix store: three 4x4 slots with dimensions and valid flags,
// loader and ALU write ports, combinational read ports A, B and R
//==========================================================================
`timescale 1ns/1ns

module matrix_store (
  input  logic                          clk,
  input  logic                          rst_n,
  // Loader write port
  input  logic                          load_wr_new,
  input  logic                          load_wr_en,
  input  logic                          load_last,
  input  logic [matrix_pkg::SLOT_W-1:0] load_slot,
  input  logic [matrix_pkg::DIM_W-1:0]  load_rows,
  input  logic [matrix_pkg::DIM_W-1:0]  load_cols,
  input  logic [matrix_pkg::DIM_W-1:0]  load_row,
  input  logic [matrix_pkg::DIM_W-1:0]  load_col,
  input  matrix_pkg::elem_t             load_data,
  // ALU write port, result slot only
  input  logic                          alu_wr_new,
  input  logic                          alu_wr_en,
  input  logic                          alu_last,
  input  logic [matrix_pkg::DIM_W-1:0]  alu_rows,
  input  logic [matrix_pkg::DIM_W-1:0]  alu_cols,
  input  logic [matrix_pkg::DIM_W-1:0]  alu_row,
  input  logic [matrix_pkg::DIM_W-1:0]  alu_col,
  input  matrix_pkg::elem_t             alu_data,
  // Read ports
  input  logic [matrix_pkg::DIM_W-1:0]  a_row,
  input  logic [matrix_pkg::DIM_W-1:0]  a_col,
  input  logic [matrix_pkg::DIM_W-1:0]  b_row,
  input  logic [matrix_pkg::DIM_W-1:0]  b_col,
  input  logic [matrix_pkg::DIM_W-1:0]  r_row,
  input  logic [matrix_pkg::DIM_W-1:0]  r_col,
  output matrix_pkg::elem_t             a_data,
  output matrix_pkg::elem_t             b_data,
  output matrix_pkg::elem_t             r_data,
  output logic [matrix_pkg::DIM_W-1:0]  a_rows,
  output logic [matrix_pkg::DIM_W-1:0]  a_cols,
  output logic [matrix_pkg::DIM_W-1:0]  b_rows,
  output logic [matrix_pkg::DIM_W-1:0]  b_cols,
  output logic [matrix_pkg::DIM_W-1:0]  r_rows,
  output logic [matrix_pkg::DIM_W-1:0]  r_cols,
  output logic [2:0]                    slot_valid
);
  import matrix_pkg::*;

  elem_t                  mem [3][MAX_DIM * MAX_DIM];
  logic [2:0][DIM_W-1:0]  rows_q;
  logic [2:0][DIM_W-1:0]  cols_q;

  // Slot metadata, ALU port wins a same-cycle clash
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rows_q     <= '0;
      cols_q     <= '0;
      slot_valid <= '0;
    end else if (alu_wr_new) begin
      rows_q[SLOT_RES]     <= alu_rows;
      cols_q[SLOT_RES]     <= alu_cols;
      slot_valid[SLOT_RES] <= 1'b0;
    end else if (alu_wr_en && alu_last) begin
      slot_valid[SLOT_RES] <= 1'b1;
    end else if (load_wr_new) begin
      rows_q[load_slot]     <= load_rows;
      cols_q[load_slot]     <= load_cols;
      slot_valid[load_slot] <= 1'b0;
    end else if (load_wr_en && load_last) begin
      slot_valid[load_slot] <= 1'b1;
    end
  end

  // Element array, address is {row, col}
  always_ff @(posedge clk) begin
    if (alu_wr_en) mem[SLOT_RES][{alu_row, alu_col}] <= alu_data;
    else if (load_wr_en) mem[load_slot][{load_row, load_col}] <= load_data;
  end

  assign a_data = mem[SLOT_A][{a_row, a_col}];
  assign b_data = mem[SLOT_B][{b_row, b_col}];
  assign r_data = mem[SLOT_RES][{r_row, r_col}];
  assign a_rows = rows_q[SLOT_A];
  assign a_cols = cols_q[SLOT_A];
  assign b_rows = rows_q[SLOT_B];
  assign b_cols = cols_q[SLOT_B];
  assign r_rows = rows_q[SLOT_RES];
  assign r_cols = cols_q[SLOT_RES];

endmodule

// ==== source/matrix_loader.sv ====
//==========================================================================
// Operand loader: header byte then row-major element bytes, turned
// into slot setup and element writes for the matrix store
//==========================================================================
`timescale 1ns/1ns

module matrix_loader (
  input  logic                               clk,
  input  logic                               rst_n,
  input  matrix_pkg::elem_t                  rx_byte,
  input  logic                               rx_valid,
  output logic                               load_wr_new,
  output logic                               load_wr_en,
  output logic                               load_last,
  output logic [matrix_pkg::SLOT_W-1:0]      load_slot,
  output logic [matrix_pkg::DIM_W-1:0]       load_rows,
  output logic [matrix_pkg::DIM_W-1:0]       load_cols,
  output logic [matrix_pkg::DIM_W-1:0]       load_row,
  output logic [matrix_pkg::DIM_W-1:0]       load_col,
  output matrix_pkg::elem_t                  load_data
);
  import matrix_pkg::*;

  typedef enum logic {
    L_HDR,
    L_ELEM
  } ld_state_t;

  ld_state_t state;
  logic      at_last;

  // Current position is the final element
  assign at_last = (load_row == load_rows) && (load_col == load_cols);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= L_HDR;
      load_wr_new <= 1'b0;
      load_wr_en  <= 1'b0;
      load_last   <= 1'b0;
      load_slot   <= SLOT_A;
      load_rows   <= '0;
      load_cols   <= '0;
      load_row    <= '0;
      load_col    <= '0;
    end else begin
      load_wr_new <= 1'b0;
      load_wr_en  <= 1'b0;
      // Step past the element just written
      if (load_wr_en) begin
        if (load_col == load_cols) begin
          load_col <= '0;
          load_row <= load_row + 1'b1;
        end else begin
          load_col <= load_col + 1'b1;
        end
      end
      if (rx_valid && state == L_HDR) begin
        load_wr_new <= 1'b1;
        load_slot   <= rx_byte[4] ? SLOT_B : SLOT_A;
        load_rows   <= rx_byte[3:2];
        load_cols   <= rx_byte[1:0];
        load_row    <= '0;
        load_col    <= '0;
        state       <= L_ELEM;
      end else if (rx_valid) begin
        load_wr_en <= 1'b1;
        load_last  <= at_last;
        if (at_last) state <= L_HDR;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && state == L_ELEM) load_data <= rx_byte;
  end

endmodule

// ==== source/uart_tx.sv ====
//==========================================================================
// UART transmitter: 10-bit frame shifter with bit and cycle counters
//==========================================================================
`timescale 1ns/1ns

module uart_tx (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              tx_start,
  input  matrix_pkg::elem_t tx_byte,
  output logic              tx_busy,
  output logic              uart_tx
);
  import matrix_pkg::*;

  logic [9:0]       frame_q;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic             bit_end;

  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  // Idle line is high
  assign uart_tx = tx_busy ? frame_q[0] : 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!tx_busy) begin
      // Start pulses while busy never reach here
      if (tx_start) begin
        tx_busy <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      // Frame ends after the stop bit
      if (bit_cnt == 4'd9) tx_busy <= 1'b0;
      else bit_cnt <= bit_cnt + 1'b1;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // Stop, data, start; shifted out from bit 0
  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) frame_q <= {1'b1, tx_byte, 1'b0};
    else if (tx_busy && bit_end) frame_q <= {1'b1, frame_q[9:1]};
  end

endmodule

// ==== source/uart_rx.sv ====
//==========================================================================
// UART receiver: input synchronizer, start edge detect, mid-bit
// sampling and stop bit check, one byte per frame
//==========================================================================
`timescale 1ns/1ns

module uart_rx (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              uart_rx,
  output matrix_pkg::elem_t rx_byte,
  output logic              rx_valid
);
  import matrix_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic [1:0]       sync_q;
  logic             rx_s;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  logic             bit_end;
  elem_t            shift_q;

  // Line level after the two sync flops
  assign rx_s    = sync_q[1];
  // Last cycle of a full bit period
  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q   <= 2'b11;
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      sync_q   <= {sync_q[0], uart_rx};
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          // Falling edge starts a frame
          if (!rx_s) state <= RX_START;
        end
        RX_START: begin
          // Middle of start bit, line must still be low
          if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= RX_STOP;
          end
        end
        default: begin
          // Stop bit sample, a low line drops the frame
          if (bit_end) begin
            rx_valid <= rx_s;
            state    <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // Data path, LSB first into the top of the shifter
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) shift_q <= {rx_s, shift_q[7:1]};
    if (state == RX_STOP && bit_end && rx_s) rx_byte <= shift_q;
  end

endmodule

// ==== source/matrix_pkg.sv ====
//==========================================================================
// Shared definitions: matrix geometry, slot numbers, element and op
// types, header byte layout and UART bit timing
//==========================================================================
package matrix_pkg;

  //==========================================================================
  // Matrix geometry and storage slots
  //==========================================================================
  // Largest row or column count
  localparam int MAX_DIM = 4;
  // Index width, dimensions are kept as count minus one
  localparam int DIM_W = 2;
  localparam int SLOT_W = 2;

  // Operand slots and the result slot
  localparam logic [SLOT_W-1:0] SLOT_A = 2'd0;
  localparam logic [SLOT_W-1:0] SLOT_B = 2'd1;
  localparam logic [SLOT_W-1:0] SLOT_RES = 2'd2;

  // Status LEDs: A valid, B valid, error, busy
  localparam int LED_W = 4;

  // UART timing, clock cycles per bit
  localparam int CLKS_PER_BIT = 8;
  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  // One element, arithmetic wraps modulo 256
  typedef logic [7:0] elem_t;

  // Op switch encoding
  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_SCALE,
    OP_TRANSPOSE
  } op_t;

  // Header byte layout
  //   bit 4    : operand slot, 0 = A, 1 = B (always 0 on output)
  //   bits 3..2: row count minus one
  //   bits 1..0: column count minus one

endpackage
